// File: design/sprite_pkg.sv
// sprite engine constants and shared record/bus types, referenced by scoped name
package sprite_pkg;

    // ====================
    // sizes and geometry
    // ====================
    localparam int num_sprites   = 64;
    localparam int attr_bytes    = 256;
    localparam int line_width    = 256;
    localparam int sprite_size   = 16;
    localparam int gfx_rom_bytes = 65536;

    // record decode offsets
    localparam int y_base = 240;
    localparam int x_bias = 128;

    // pen that leaves the line buffer untouched
    localparam logic [3:0] trans_pen = 4'd0;

    // ====================
    // host bus
    // ====================
    localparam int axil_aw = 18;
    localparam int axil_dw = 32;

    localparam logic [1:0] resp_okay   = 2'd0;
    localparam logic [1:0] resp_slverr = 2'd2;

    // address bits 17:16
    localparam logic [1:0] region_attr = 2'd0;
    localparam logic [1:0] region_gfx  = 2'd1;
    localparam logic [1:0] region_line = 2'd2;

    // one decoded sprite list entry
    typedef struct packed {
        logic [8:0] tile;
        logic [8:0] x_pos;
        logic [7:0] y_pos;
        logic [3:0] colour;
        logic       flip_x;
        logic       flip_y;
    } sprite_attr_t;

    // target 0 is attribute RAM, 1 is graphics ROM
    typedef struct packed {
        logic        valid;
        logic        target;
        logic [15:0] addr;
        logic [7:0]  data;
    } mem_wr_t;

    typedef struct packed {
        logic       valid;
        logic [7:0] x;
    } line_rd_t;

    typedef struct packed {
        logic                 awvalid;
        logic [axil_aw-1:0]   awaddr;
        logic                 wvalid;
        logic [axil_dw-1:0]   wdata;
        logic [axil_dw/8-1:0] wstrb;
        logic                 bready;
        logic                 arvalid;
        logic [axil_aw-1:0]   araddr;
        logic                 rready;
    } axil_req_t;

    typedef struct packed {
        logic               awready;
        logic               wready;
        logic               bvalid;
        logic [1:0]         bresp;
        logic               arready;
        logic               rvalid;
        logic [axil_dw-1:0] rdata;
        logic [1:0]         rresp;
    } axil_rsp_t;

    typedef struct packed {
        logic [3:0] colour;
        logic [3:0] pen;
    } pixel_t;

endpackage

// File: design/axil_sprite_port.sv
// AXI4-Lite slave that turns host accesses into sprite engine memory writes and pixel reads
`timescale 1ns/1ps

module axil_sprite_port (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  sprite_pkg::axil_req_t axil_req,
    output sprite_pkg::axil_rsp_t axil_rsp,
    input  logic                  busy,
    output sprite_pkg::mem_wr_t   mem_wr,
    output sprite_pkg::line_rd_t  line_rd,
    input  sprite_pkg::pixel_t    pixel
);

    logic [1:0] wr_region;
    logic [1:0] rd_region;
    logic       wr_ok;
    logic       wr_fire;
    logic       arready;
    logic       rd_fire;

    logic       bvalid;
    logic [1:0] bresp;
    logic       rd_wait;
    logic       rd_is_line;
    logic       rvalid;
    logic [1:0] rresp;
    logic [sprite_pkg::axil_dw-1:0] rdata;

    assign wr_region = axil_req.awaddr[17:16];
    assign rd_region = axil_req.araddr[17:16];
    assign wr_ok     = (wr_region == sprite_pkg::region_attr) ||
                       (wr_region == sprite_pkg::region_gfx);

    // aw and w taken together and held off by a pending response or engine activity
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid && !busy;
    assign arready = !rd_wait && !rvalid && !busy;
    assign rd_fire = axil_req.arvalid && arready;

    // ====================
    // internal requests
    // ====================
    always_comb begin
        mem_wr.valid  = wr_fire && axil_req.wstrb[0] && wr_ok;
        mem_wr.target = (wr_region == sprite_pkg::region_gfx);
        mem_wr.addr   = axil_req.awaddr[15:0];
        mem_wr.data   = axil_req.wdata[7:0];
        line_rd.valid = rd_fire && (rd_region == sprite_pkg::region_line);
        line_rd.x     = axil_req.araddr[7:0];
    end

    // ====================
    // write response
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wr_fire) begin
            bresp <= wr_ok ? sprite_pkg::resp_okay : sprite_pkg::resp_slverr;
        end
    end

    // ====================
    // read response
    // ====================
    // one wait cycle while the line buffer answers
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            rd_wait <= 1'b0;
            rvalid  <= 1'b0;
        end else begin
            rd_wait <= rd_fire;
            if (rd_wait) begin
                rvalid <= 1'b1;
            end else if (axil_req.rready) begin
                rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rd_fire) begin
            rd_is_line <= (rd_region == sprite_pkg::region_line);
        end
        if (rd_wait) begin
            rdata <= rd_is_line ? {{(sprite_pkg::axil_dw - 8){1'b0}}, pixel} : '0;
            rresp <= rd_is_line ? sprite_pkg::resp_okay : sprite_pkg::resp_slverr;
        end
    end

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready  = wr_fire;
        axil_rsp.bvalid  = bvalid;
        axil_rsp.bresp   = bresp;
        axil_rsp.arready = arready;
        axil_rsp.rvalid  = rvalid;
        axil_rsp.rdata   = rdata;
        axil_rsp.rresp   = rresp;
    end

    // responses are held until the master takes them
    a_bvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
        bvalid && !axil_req.bready |=> bvalid);
    a_rvalid_hold: assert property (@(posedge clk_sys) disable iff (reset)
        rvalid && !axil_req.rready |=> rvalid);

endmodule

// File: design/sprite_list_copier.sv
// attribute RAM and sprite table, copies and decodes all 64 records on each frame start
`timescale 1ns/1ps

module sprite_list_copier (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  sprite_pkg::mem_wr_t      mem_wr,
    input  logic                     frame_start,
    input  logic                     line_busy,
    output logic                     frame_busy,
    input  logic [5:0]               table_idx,
    output sprite_pkg::sprite_attr_t table_entry
);

    typedef enum logic [1:0] {
        c_idle,
        c_read,
        c_last
    } copy_state_t;

    copy_state_t state;
    logic [6:0]  copy_idx;
    logic [1:0]  byte_sel;

    logic [7:0] attr_ram [sprite_pkg::attr_bytes];
    logic [7:0] attr_q;
    logic [7:0] rec_y;
    logic [7:0] rec_tile;
    logic [7:0] rec_flags;

    sprite_pkg::sprite_attr_t sprite_table [sprite_pkg::num_sprites];
    sprite_pkg::sprite_attr_t new_entry;

    assign frame_busy = (state != c_idle);

    // host writes one port, the copy reads the other
    always_ff @(posedge clk_sys) begin
        if (mem_wr.valid && !mem_wr.target) begin
            attr_ram[mem_wr.addr[7:0]] <= mem_wr.data;
        end
        attr_q <= attr_ram[{copy_idx[5:0], byte_sel}];
    end

    // ====================
    // copy FSM
    // ====================
    // four reads per record, then one table write
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state    <= c_idle;
            copy_idx <= '0;
            byte_sel <= '0;
        end else begin
            case (state)
                c_idle: begin
                    if (frame_start && !line_busy) begin
                        state    <= c_read;
                        copy_idx <= '0;
                        byte_sel <= '0;
                    end
                end
                c_read: begin
                    byte_sel <= byte_sel + 2'd1;
                    if (byte_sel == 2'd3) begin
                        state <= c_last;
                    end
                end
                default: begin
                    copy_idx <= copy_idx + 7'd1;
                    if (copy_idx == 7'(sprite_pkg::num_sprites - 1)) begin
                        state <= c_idle;
                    end else begin
                        state <= c_read;
                    end
                end
            endcase
        end
    end

    // byte 3 arrives in c_last and goes straight into the entry
    always_comb begin
        new_entry.tile   = {rec_flags[1], rec_tile};
        new_entry.x_pos  = {rec_flags[0], attr_q} - 9'(sprite_pkg::x_bias);
        new_entry.y_pos  = rec_y;
        new_entry.colour = rec_flags[7:4];
        new_entry.flip_x = rec_flags[2];
        new_entry.flip_y = rec_flags[3];
    end

    // attr_q lags the read address by one byte
    always_ff @(posedge clk_sys) begin
        if (state == c_read) begin
            case (byte_sel)
                2'd1: rec_y <= 8'(sprite_pkg::y_base) - attr_q;
                2'd2: rec_tile <= attr_q;
                2'd3: rec_flags <= attr_q;
                default: ;
            endcase
        end
        if (state == c_last) begin
            sprite_table[copy_idx[5:0]] <= new_entry;
        end
        table_entry <= sprite_table[table_idx];
    end

    // the copy ends on entry 63 and never runs past it
    a_idx_range: assert property (@(posedge clk_sys) disable iff (reset)
        frame_busy |-> copy_idx < 7'(sprite_pkg::num_sprites));

endmodule

// File: design/sprite_line_renderer.sv
// sprite line renderer that clears the line buffer and then draws every sprite covering the line
`timescale 1ns/1ps

module sprite_line_renderer (
    input  logic                     clk_sys,
    input  logic                     reset,
    input  sprite_pkg::mem_wr_t      mem_wr,
    input  logic                     line_start,
    input  logic [7:0]               line_y,
    input  logic                     frame_busy,
    output logic                     line_busy,
    output logic [5:0]               table_idx,
    input  sprite_pkg::sprite_attr_t table_entry,
    input  sprite_pkg::line_rd_t     line_rd,
    output sprite_pkg::pixel_t       pixel
);

    typedef enum logic [2:0] {
        r_idle,
        r_clear,
        r_fetch,
        r_test,
        r_rom,
        r_write,
        r_next
    } draw_state_t;

    draw_state_t state;
    logic [7:0]  cur_y;
    logic [7:0]  clr_x;
    logic [3:0]  col;

    sprite_pkg::sprite_attr_t spr;

    logic [7:0]         gfx_rom [sprite_pkg::gfx_rom_bytes];
    logic [7:0]         rom_q;
    sprite_pkg::pixel_t line_buf [sprite_pkg::line_width];

    logic        hit;
    logic [3:0]  row;
    logic [3:0]  eff_row;
    logic [3:0]  eff_col;
    logic [15:0] rom_addr;
    logic [3:0]  pen;
    logic [9:0]  draw_x;
    logic        off_line;

    logic               lb_we;
    logic [7:0]         lb_addr;
    sprite_pkg::pixel_t lb_data;

    assign line_busy = (state != r_idle);

    // ====================
    // sprite geometry
    // ====================
    // 9-bit compare so y_pos near the bottom does not wrap
    assign hit = ({1'b0, cur_y} >= {1'b0, table_entry.y_pos}) &&
                 ({1'b0, cur_y} < {1'b0, table_entry.y_pos} + 9'(sprite_pkg::sprite_size));

    assign row      = 4'(cur_y - spr.y_pos);
    assign eff_row  = spr.flip_y ? 4'd15 - row : row;
    assign eff_col  = spr.flip_x ? 4'd15 - col : col;
    assign rom_addr = {eff_col[1], spr.tile, eff_row, eff_col[3:2]};
    // odd columns sit in the high nibble
    assign pen      = eff_col[0] ? rom_q[7:4] : rom_q[3:0];
    assign draw_x   = {1'b0, spr.x_pos} + 10'(col);
    assign off_line = (draw_x >= 10'(sprite_pkg::line_width));

    always_ff @(posedge clk_sys) begin
        if (mem_wr.valid && mem_wr.target) begin
            gfx_rom[mem_wr.addr] <= mem_wr.data;
        end
        rom_q <= gfx_rom[rom_addr];
    end

    // clear pass writes zeros and draw pass writes opaque pens
    always_comb begin
        lb_we   = 1'b0;
        lb_addr = clr_x;
        lb_data = '0;
        if (state == r_clear) begin
            lb_we = 1'b1;
        end else if (state == r_write && !off_line && pen != sprite_pkg::trans_pen) begin
            lb_we   = 1'b1;
            lb_addr = draw_x[7:0];
            lb_data = {spr.colour, pen};
        end
    end

    always_ff @(posedge clk_sys) begin
        if (lb_we) begin
            line_buf[lb_addr] <= lb_data;
        end
        if (line_rd.valid) begin
            pixel <= line_buf[line_rd.x];
        end
    end

    // ====================
    // clear/draw FSM
    // ====================
    always_ff @(posedge clk_sys) begin
        if (reset) begin
            state     <= r_idle;
            clr_x     <= '0;
            col       <= '0;
            table_idx <= '0;
        end else begin
            case (state)
                r_idle: begin
                    if (line_start && !frame_busy) begin
                        state <= r_clear;
                        clr_x <= '0;
                        cur_y <= line_y;
                    end
                end
                r_clear: begin
                    clr_x <= clr_x + 8'd1;
                    if (clr_x == 8'(sprite_pkg::line_width - 1)) begin
                        state     <= r_fetch;
                        table_idx <= '0;
                    end
                end
                // table answers one cycle after table_idx
                r_fetch: state <= r_test;
                r_test: begin
                    spr   <= table_entry;
                    col   <= '0;
                    state <= hit ? r_rom : r_next;
                end
                r_rom: state <= r_write;
                r_write: begin
                    if (off_line || col == 4'(sprite_pkg::sprite_size - 1)) begin
                        state <= r_next;
                    end else begin
                        col   <= col + 4'd1;
                        state <= r_rom;
                    end
                end
                default: begin
                    if (table_idx == 6'(sprite_pkg::num_sprites - 1)) begin
                        state <= r_idle;
                    end else begin
                        table_idx <= table_idx + 6'd1;
                        state     <= r_fetch;
                    end
                end
            endcase
        end
    end

    // host writes and pixel reads stay out of a copy or a render
    a_host_idle: assert property (@(posedge clk_sys) disable iff (reset)
        (mem_wr.valid || line_rd.valid) |-> !(line_busy || frame_busy));

endmodule

// File: design/sprite_engine.sv
// sprite engine top, joins the host port, the list copier and the line renderer
`timescale 1ns/1ps

module sprite_engine (
    input  logic                  clk_sys,
    input  logic                  reset,
    input  sprite_pkg::axil_req_t axil_req,
    output sprite_pkg::axil_rsp_t axil_rsp,
    input  logic                  frame_start,
    input  logic                  line_start,
    input  logic [7:0]            line_y,
    output logic                  frame_busy,
    output logic                  line_busy
);

    sprite_pkg::mem_wr_t      mem_wr;
    sprite_pkg::line_rd_t     line_rd;
    sprite_pkg::pixel_t       pixel;
    logic [5:0]               table_idx;
    sprite_pkg::sprite_attr_t table_entry;

    // host accesses wait out both copy and render
    axil_sprite_port u_port (
        .clk_sys  (clk_sys),
        .reset    (reset),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp),
        .busy     (frame_busy | line_busy),
        .mem_wr   (mem_wr),
        .line_rd  (line_rd),
        .pixel    (pixel)
    );

    sprite_list_copier u_copier (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .mem_wr      (mem_wr),
        .frame_start (frame_start),
        .line_busy   (line_busy),
        .frame_busy  (frame_busy),
        .table_idx   (table_idx),
        .table_entry (table_entry)
    );

    sprite_line_renderer u_renderer (
        .clk_sys     (clk_sys),
        .reset       (reset),
        .mem_wr      (mem_wr),
        .line_start  (line_start),
        .line_y      (line_y),
        .frame_busy  (frame_busy),
        .line_busy   (line_busy),
        .table_idx   (table_idx),
        .table_entry (table_entry),
        .line_rd     (line_rd),
        .pixel       (pixel)
    );

endmodule

// File: tb/sprite_model.svh
// reference model of record decode and line drawing, included inside the sprite engine testbench
`ifndef SPRITE_MODEL_SVH
`define SPRITE_MODEL_SVH

// ====================
// memory images
// ====================
logic [7:0] attr_image [sprite_pkg::attr_bytes];
logic [7:0] rom_image [sprite_pkg::gfx_rom_bytes];
logic [7:0] expected_line [sprite_pkg::line_width];

// decoded table, latched at each frame start
int tbl_tile [sprite_pkg::num_sprites];
int tbl_x [sprite_pkg::num_sprites];
int tbl_y [sprite_pkg::num_sprites];
int tbl_colour [sprite_pkg::num_sprites];
bit tbl_flip_x [sprite_pkg::num_sprites];
bit tbl_flip_y [sprite_pkg::num_sprites];

task automatic copy_sprite_list();
    int rec;
    int raw_x;
    for (rec = 0; rec < sprite_pkg::num_sprites; rec++) begin
        tbl_y[rec] = (sprite_pkg::y_base - int'(attr_image[rec * 4])) & 255;
        tbl_tile[rec] = (int'(attr_image[rec * 4 + 2][1]) << 8) | int'(attr_image[rec * 4 + 1]);
        // 9-bit x with the bias taken off, wraps like the hardware
        raw_x = (int'(attr_image[rec * 4 + 2][0]) << 8) | int'(attr_image[rec * 4 + 3]);
        tbl_x[rec] = (raw_x - sprite_pkg::x_bias) & 511;
        tbl_colour[rec] = int'(attr_image[rec * 4 + 2][7:4]);
        tbl_flip_x[rec] = attr_image[rec * 4 + 2][2];
        tbl_flip_y[rec] = attr_image[rec * 4 + 2][3];
    end
endtask

task automatic draw_expected_line(input int y);
    int s;
    int c;
    int x;
    int row;
    int ecol;
    int addr;
    logic [7:0] rom_byte;
    logic [3:0] pen;
    for (x = 0; x < sprite_pkg::line_width; x++) begin
        expected_line[x] = 8'h00;
    end
    // later entries land on top
    for (s = 0; s < sprite_pkg::num_sprites; s++) begin
        if (y >= tbl_y[s] && y < tbl_y[s] + sprite_pkg::sprite_size) begin
            row = tbl_flip_y[s] ? 15 - (y - tbl_y[s]) : y - tbl_y[s];
            for (c = 0; c < sprite_pkg::sprite_size; c++) begin
                x = tbl_x[s] + c;
                if (x >= sprite_pkg::line_width) begin
                    break;
                end
                ecol = tbl_flip_x[s] ? 15 - c : c;
                addr = (((ecol >> 1) & 1) << 15) | (tbl_tile[s] << 6) | (row << 2) | (ecol >> 2);
                rom_byte = rom_image[addr];
                pen = ((ecol & 1) != 0) ? rom_byte[7:4] : rom_byte[3:0];
                if (pen != sprite_pkg::trans_pen) begin
                    expected_line[x] = {4'(tbl_colour[s]), pen};
                end
            end
        end
    end
endtask

`endif

// File: tb/sprite_engine_tb.sv
// self-checking testbench that compares random sprite frames with the included model
`timescale 1ns/1ps

module sprite_engine_tb;

    localparam int num_trials = 12;
    localparam int seed       = 69398;
    localparam int max_tiles  = 8;

    logic                  clk_sys;
    logic                  reset;
    sprite_pkg::axil_req_t axil_req;
    sprite_pkg::axil_rsp_t axil_rsp;
    logic                  frame_start;
    logic                  line_start;
    logic [7:0]            line_y;
    logic                  frame_busy;
    logic                  line_busy;

    int unsigned lcg_state   = seed;
    int          error_count = 0;
    int          check_count = 0;

    `include "sprite_model.svh"

    sprite_engine dut (.*);

    initial begin
        clk_sys = 1'b0;
        forever #2 clk_sys = ~clk_sys;
    end

    initial begin
        #(num_trials * 20000);
        $display("timeout: the run did not finish within %0d ns", num_trials * 20000);
        $display("checks %0d, errors %0d", check_count, error_count);
        $display("Result: FAILED");
        $finish;
    end

    function automatic int unsigned next_rand();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state >> 16;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("[ERROR] %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // drive point is 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    task automatic axil_write(input logic [17:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, output logic [1:0] resp);
        logic done;
        logic ready;
        axil_req.awvalid = 1'b1;
        axil_req.awaddr  = addr;
        axil_req.wvalid  = 1'b1;
        axil_req.wdata   = data;
        axil_req.wstrb   = strb;
        done = 1'b0;
        while (!done) begin
            #1;
            // no response is pending here, so only a busy engine holds the write off
            ready = !(frame_busy || line_busy);
            check_value("awready", 32'(axil_rsp.awready), 32'(ready));
            check_value("wready", 32'(axil_rsp.wready), 32'(ready));
            done = axil_rsp.awready && axil_rsp.wready;
            next_cycle();
        end
        axil_req.awvalid = 1'b0;
        axil_req.wvalid  = 1'b0;
        axil_req.bready  = 1'b1;
        done = 1'b0;
        while (!done) begin
            #1;
            done = axil_rsp.bvalid;
            resp = axil_rsp.bresp;
            next_cycle();
        end
        axil_req.bready = 1'b0;
    endtask

    task automatic axil_read(input logic [17:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        logic done;
        axil_req.arvalid = 1'b1;
        axil_req.araddr  = addr;
        done = 1'b0;
        while (!done) begin
            #1;
            done = axil_rsp.arready;
            next_cycle();
        end
        axil_req.arvalid = 1'b0;
        axil_req.rready  = 1'b1;
        done = 1'b0;
        while (!done) begin
            #1;
            done = axil_rsp.rvalid;
            data = axil_rsp.rdata;
            resp = axil_rsp.rresp;
            next_cycle();
        end
        axil_req.rready = 1'b0;
    endtask

    task automatic attr_write(input logic [7:0] idx, input logic [7:0] data);
        logic [1:0] resp;
        axil_write({sprite_pkg::region_attr, 8'd0, idx}, {24'd0, data}, 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(sprite_pkg::resp_okay));
        attr_image[idx] = data;
    endtask

    task automatic wait_idle();
        #1;
        while (frame_busy || line_busy) begin
            @(posedge clk_sys);
            #2;
        end
        next_cycle();
    endtask

    task automatic start_frame();
        frame_start = 1'b1;
        next_cycle();
        frame_start = 1'b0;
        copy_sprite_list();
        check_value("frame_busy", 32'(frame_busy), 32'd1);
    endtask

    task automatic render_line(input logic [7:0] y);
        logic [31:0] rdata;
        logic [1:0]  resp;
        int          x;
        line_y     = y;
        line_start = 1'b1;
        next_cycle();
        line_start = 1'b0;
        check_value("line_busy", 32'(line_busy), 32'd1);
        wait_idle();
        draw_expected_line(int'(y));
        for (x = 0; x < sprite_pkg::line_width; x++) begin
            axil_read({sprite_pkg::region_line, 8'd0, 8'(x)}, rdata, resp);
            check_value("rresp", 32'(resp), 32'(sprite_pkg::resp_okay));
            check_value($sformatf("pixel[%0d]", x), rdata, {24'd0, expected_line[x]});
        end
    endtask

    initial begin
        int          i;
        int          t;
        int          s;
        int          center;
        int          ypos;
        int          xpos;
        logic [15:0] addr;
        logic [7:0]  data;
        logic [8:0]  raw_x;
        logic [31:0] rdata;
        logic [1:0]  resp;

        axil_req    = '0;
        frame_start = 1'b0;
        line_start  = 1'b0;
        line_y      = 8'd0;
        reset       = 1'b1;
        repeat (16) @(posedge clk_sys);
        #1;
        reset = 1'b0;
        #1;
        check_value("frame_busy", 32'(frame_busy), 32'd0);
        check_value("line_busy", 32'(line_busy), 32'd0);
        check_value("bvalid", 32'(axil_rsp.bvalid), 32'd0);
        check_value("rvalid", 32'(axil_rsp.rvalid), 32'd0);
        next_cycle();

        // graphics for tiles 0 to 7 in both column halves
        for (i = 0; i < 2 * max_tiles * 64; i++) begin
            addr = {i[9], 6'd0, i[8:0]};
            data = 8'(next_rand());
            axil_write({sprite_pkg::region_gfx, addr}, {24'd0, data}, 4'hf, resp);
            check_value("bresp", 32'(resp), 32'(sprite_pkg::resp_okay));
            rom_image[addr] = data;
        end

        // ====================
        // all sprites off-screen
        // ====================
        for (i = 0; i < sprite_pkg::attr_bytes; i++) begin
            attr_write(8'(i), 8'd0);
        end
        start_frame();
        wait_idle();
        render_line(8'd100);

        // bad regions
        axil_write({sprite_pkg::region_line, 16'h0005}, 32'h5a, 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(sprite_pkg::resp_slverr));
        axil_write({2'd3, 16'h0000}, 32'h5a, 4'hf, resp);
        check_value("bresp", 32'(resp), 32'(sprite_pkg::resp_slverr));
        axil_read({sprite_pkg::region_attr, 16'h0010}, rdata, resp);
        check_value("rresp", 32'(resp), 32'(sprite_pkg::resp_slverr));
        check_value("rdata", rdata, 32'd0);
        axil_read({sprite_pkg::region_gfx, 16'h0000}, rdata, resp);
        check_value("rresp", 32'(resp), 32'(sprite_pkg::resp_slverr));

        // ====================
        // random frames
        // ====================
        for (t = 0; t < num_trials; t++) begin
            center = 16 + int'(next_rand() % 224);
            for (s = 0; s < sprite_pkg::num_sprites; s++) begin
                ypos  = (center - int'(next_rand() % 32)) & 255;
                xpos  = int'(next_rand() % 272);
                raw_x = 9'(xpos + sprite_pkg::x_bias);
                attr_write(8'(s * 4), 8'(sprite_pkg::y_base - ypos));
                attr_write(8'(s * 4 + 1), 8'(next_rand() % max_tiles));
                attr_write(8'(s * 4 + 2), {4'(next_rand()), 2'(next_rand()), 1'b0, raw_x[8]});
                attr_write(8'(s * 4 + 3), raw_x[7:0]);
            end
            // byte lane 0 disabled so the image keeps the old byte
            addr = 16'(next_rand() % 256);
            axil_write({sprite_pkg::region_attr, addr}, {24'd0, ~attr_image[addr[7:0]]},
                       4'he, resp);
            check_value("bresp", 32'(resp), 32'(sprite_pkg::resp_okay));
            start_frame();
            wait_idle();
            render_line(8'(center - int'(next_rand() % 16)));
        end

        // write held off by the copy lands in the next frame only
        start_frame();
        attr_write(8'd252, 8'(sprite_pkg::y_base - 45));
        check_value("frame_busy", 32'(frame_busy), 32'd0);
        attr_write(8'd253, 8'd3);
        attr_write(8'd254, 8'ha4);
        attr_write(8'd255, 8'(100 + sprite_pkg::x_bias));
        render_line(8'd50);
        start_frame();
        wait_idle();
        render_line(8'd50);

        $display("checks %0d, errors %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
+incdir+tb
design/sprite_pkg.sv
design/axil_sprite_port.sv
design/sprite_list_copier.sv
design/sprite_line_renderer.sv
design/sprite_engine.sv
tb/sprite_engine_tb.sv

// File: Makefile
# Verilator build and run of the sprite engine testbench

VERILATOR ?= verilator
TOP       ?= sprite_engine_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal

SOURCES := $(shell grep -v '^+' $(FILELIST)) tb/sprite_model.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	@grep -q "Result: PASSED" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
